// ==== source/apuPkg.sv ====
package apuPkg;

    // widths with a meaning of their own
    typedef logic [7:0]  regByte_t;      // one CPU-visible control byte
    typedef logic [3:0]  volume_t;
    typedef logic [10:0] timerPeriod_t;  // timer reload, in cpu_clk cycles minus one
    typedef logic [6:0]  lengthCount_t;

    // decoded channel controls
    // reg0 carries duty to volumeOrPeriod
    // reg1 carries the sweep fields
    // reg2 and reg3 carry timerPeriod and lengthIndex
    typedef struct packed {
        logic [1:0]   duty;            // 12.5 / 25 / 50 / 75 %
        logic         lengthHalt;      // also envelope loop
        logic         constVolume;
        volume_t      volumeOrPeriod;  // volume or envelope divider
        logic         sweepEnable;
        logic [2:0]   sweepPeriod;
        logic         sweepNegate;
        logic [2:0]   sweepShift;
        timerPeriod_t timerPeriod;
        logic [4:0]   lengthIndex;
    } pulseCfg_t;

    // one-cycle strobes out of the frame sequencer
    typedef struct packed {
        logic quarterTick;  // envelope clock
        logic halfTick;     // length and sweep clock
    } frameTicks_t;

    // frame sequencer position
    // 4-step mode wraps after STEP3, 5-step mode after STEP4
    typedef enum logic [2:0] {
        STEP0,
        STEP1,
        STEP2,
        STEP3,
        STEP4
    } frameStep_t;

endpackage

// ==== source/pulseRegDecode.sv ====
module pulseRegDecode (
    input  logic              cpu_clk,
    input  logic              rstn,
    input  logic              writeEn,
    input  logic [1:0]        writeAddr,
    input  apuPkg::regByte_t  writeData,
    output apuPkg::pulseCfg_t cfg,
    output logic              restart
);

    apuPkg::regByte_t ctrlReg [4];  // the four channel registers

    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 4; i++) begin
                ctrlReg[i] <= '0;
            end
        end else if (writeEn) begin
            ctrlReg[writeAddr] <= writeData;
        end
    end

    // a write to reg3 restarts timer, envelope, sweep and length
    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            restart <= 1'b0;
        end else begin
            restart <= writeEn && (writeAddr == 2'd3);
        end
    end

    // field slicing, straight from the register bytes
    always_comb begin
        // reg0: duty, halt/loop, const volume, volume or envelope period
        cfg.duty           = ctrlReg[0][7:6];
        cfg.lengthHalt     = ctrlReg[0][5];
        cfg.constVolume    = ctrlReg[0][4];
        cfg.volumeOrPeriod = ctrlReg[0][3:0];

        // reg1: sweep controls
        cfg.sweepEnable    = ctrlReg[1][7];
        cfg.sweepPeriod    = ctrlReg[1][6:4];
        cfg.sweepNegate    = ctrlReg[1][3];
        cfg.sweepShift     = ctrlReg[1][2:0];

        // reg2 low period bits, reg3 high period bits and length index
        cfg.timerPeriod    = {ctrlReg[3][2:0], ctrlReg[2]};
        cfg.lengthIndex    = ctrlReg[3][7:3];
    end

endmodule

// ==== source/apuFrameSequencer.sv ====
module apuFrameSequencer (
    input  logic                cpu_clk,
    input  logic                rstn,
    input  logic                frameTick,   // 240 Hz strobe
    input  logic                stepSel,     // 0: 4-step, 1: 5-step
    input  logic                enableIntr,
    output apuPkg::frameTicks_t ticks,
    output logic                frameIrq
);

    apuPkg::frameStep_t  step;
    apuPkg::frameStep_t  stepNext;
    apuPkg::frameTicks_t tickDecode;
    logic                lastStep;

    // step decode and wrap point
    always_comb begin
        if (stepSel) begin
            lastStep               = (step == apuPkg::STEP4);
            tickDecode.quarterTick = (step != apuPkg::STEP4);  // steps 0 to 3
            tickDecode.halfTick    = (step == apuPkg::STEP1) || (step == apuPkg::STEP4);
        end else begin
            // STEP4 can only be left over from a mode change, wrap it too
            lastStep               = (step == apuPkg::STEP3) || (step == apuPkg::STEP4);
            tickDecode.quarterTick = 1'b1;
            tickDecode.halfTick    = (step == apuPkg::STEP1) || (step == apuPkg::STEP3);
        end

        if (lastStep) begin
            stepNext = apuPkg::STEP0;
        end else begin
            stepNext = apuPkg::frameStep_t'(step + 3'd1);
        end
    end

    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            step  <= apuPkg::STEP0;
            ticks <= '0;
        end else begin
            ticks <= frameTick ? tickDecode : '0;  // one-cycle strobes
            if (frameTick) begin
                step <= stepNext;
            end
        end
    end

    // irq only from the last step of 4-step mode, held until enableIntr drops
    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            frameIrq <= 1'b0;
        end else if (!enableIntr) begin
            frameIrq <= 1'b0;
        end else if (frameTick && !stepSel && (step == apuPkg::STEP3)) begin
            frameIrq <= 1'b1;
        end
    end

endmodule

// ==== source/pulseEnvelope.sv ====
module pulseEnvelope (
    input  logic              cpu_clk,
    input  logic              rstn,
    input  apuPkg::pulseCfg_t cfg,
    input  logic              restart,
    input  logic              quarterTick,
    output apuPkg::volume_t   volume
);

    apuPkg::volume_t envDivider;  // counts volumeOrPeriod down to 0
    apuPkg::volume_t decayLevel;

    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            envDivider <= '0;
            decayLevel <= '0;
        end else if (restart) begin
            // fresh note starts at full level
            envDivider <= cfg.volumeOrPeriod;
            decayLevel <= 4'd15;
        end else if (quarterTick) begin
            if (envDivider == 4'd0) begin
                envDivider <= cfg.volumeOrPeriod;
                if (decayLevel != 4'd0) begin
                    decayLevel <= decayLevel - 4'd1;
                end else if (cfg.lengthHalt) begin
                    decayLevel <= 4'd15;  // loop mode
                end
            end else begin
                envDivider <= envDivider - 4'd1;
            end
        end
    end

    // constant volume bypasses the decay level
    assign volume = cfg.constVolume ? cfg.volumeOrPeriod : decayLevel;

endmodule

// ==== source/pulseSweep.sv ====
module pulseSweep #(
    parameter int unsigned SWEEP_MUTE_MIN = 8  // lowest period still audible
) (
    input  logic                 cpu_clk,
    input  logic                 rstn,
    input  apuPkg::pulseCfg_t    cfg,
    input  logic                 restart,
    input  logic                 halfTick,
    input  logic                 timerTick,
    output apuPkg::timerPeriod_t curPeriod,
    output logic                 sweepMute
);

    apuPkg::timerPeriod_t shiftAmount;
    apuPkg::timerPeriod_t subTarget;
    apuPkg::timerPeriod_t nextPeriod;
    logic [11:0]          addTarget;   // one extra bit for overflow
    logic [2:0]           sweepDiv;
    logic                 sweepGo;
    logic                 updatePending;

    // target period, both directions
    assign shiftAmount = curPeriod >> cfg.sweepShift;
    assign addTarget   = {1'b0, curPeriod} + {1'b0, shiftAmount};
    assign subTarget   = curPeriod - shiftAmount;
    assign nextPeriod  = cfg.sweepNegate ? subTarget : addTarget[10:0];

    // too low a period, or an add past 2047, silences the channel
    assign sweepMute = (curPeriod < apuPkg::timerPeriod_t'(SWEEP_MUTE_MIN))
                    || (!cfg.sweepNegate && addTarget[11]);

    assign sweepGo = cfg.sweepEnable && (cfg.sweepShift != 3'd0) && !sweepMute;

    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            curPeriod     <= '0;
            sweepDiv      <= '0;
            updatePending <= 1'b0;
        end else if (restart) begin
            curPeriod     <= cfg.timerPeriod;
            sweepDiv      <= cfg.sweepPeriod;
            updatePending <= 1'b0;
        end else begin
            // apply only at a timer reload, so no duty step gets shortened
            if (updatePending && timerTick) begin
                updatePending <= 1'b0;
                if (sweepGo) begin
                    curPeriod <= nextPeriod;
                end
            end

            // divider end arms the next update, wins over the clear above
            if (halfTick) begin
                if (sweepDiv == 3'd0) begin
                    sweepDiv <= cfg.sweepPeriod;
                    if (sweepGo) begin
                        updatePending <= 1'b1;
                    end
                end else begin
                    sweepDiv <= sweepDiv - 3'd1;
                end
            end
        end
    end

endmodule

// ==== source/pulseWaveGen.sv ====
module pulseWaveGen (
    input  logic                 cpu_clk,
    input  logic                 rstn,
    input  apuPkg::pulseCfg_t    cfg,
    input  logic                 restart,
    input  logic                 halfTick,
    input  apuPkg::timerPeriod_t curPeriod,
    input  logic                 sweepMute,
    input  apuPkg::volume_t      volume,
    output logic                 timerTick,
    output apuPkg::volume_t      outVolume
);

    apuPkg::timerPeriod_t timerCnt;
    apuPkg::lengthCount_t lengthCnt;
    apuPkg::lengthCount_t lengthLoad;
    logic [2:0]           seqStep;      // duty sequencer position
    logic [7:0]           dutyPattern;
    logic                 chanActive;

    // high steps per 8-step cycle: 1, 2, 4 or 6
    always_comb begin
        case (cfg.duty)
            2'd0:    dutyPattern = 8'b0000_0001;  // 12.5 %
            2'd1:    dutyPattern = 8'b0000_0011;  // 25 %
            2'd2:    dutyPattern = 8'b0000_1111;  // 50 %
            default: dutyPattern = 8'b0011_1111;  // 75 %
        endcase
    end

    // length load is (index + 1) * 2
    assign lengthLoad = {6'(cfg.lengthIndex) + 6'd1, 1'b0};

    // timer, each duty step lasts curPeriod + 1 cycles
    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            timerCnt  <= '0;
            seqStep   <= '0;
            timerTick <= 1'b0;
        end else if (restart) begin
            // sweep loads the same value into curPeriod on this edge
            timerCnt  <= cfg.timerPeriod;
            seqStep   <= '0;
            timerTick <= 1'b0;
        end else if (timerCnt == '0) begin
            timerCnt  <= curPeriod;
            seqStep   <= seqStep + 3'd1;
            timerTick <= 1'b1;
        end else begin
            timerCnt  <= timerCnt - 11'd1;
            timerTick <= 1'b0;
        end
    end

    // length counter
    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            lengthCnt <= '0;  // silent until reg3 is written
        end else if (restart) begin
            lengthCnt <= lengthLoad;
        end else if (halfTick && !cfg.lengthHalt && (lengthCnt != '0)) begin
            lengthCnt <= lengthCnt - 7'd1;
        end
    end

    assign chanActive = (lengthCnt != '0) && !sweepMute;

    // gated output, one cycle behind the duty step
    always_ff @(posedge cpu_clk or negedge rstn) begin
        if (!rstn) begin
            outVolume <= '0;
        end else if (dutyPattern[seqStep] && chanActive) begin
            outVolume <= volume;
        end else begin
            outVolume <= '0;
        end
    end

endmodule

// ==== source/apuPulseTop.sv ====
module apuPulseTop #(
    parameter int unsigned SWEEP_MUTE_MIN = 8
) (
    input  logic             cpu_clk,
    input  logic             rstn,
    input  logic             writeEn,
    input  logic [1:0]       writeAddr,
    input  apuPkg::regByte_t writeData,
    input  logic             frameTick,
    input  logic             stepSel,
    input  logic             enableIntr,
    output apuPkg::volume_t  outVolume,
    output logic             frameIrq
);

    apuPkg::pulseCfg_t    cfg;
    apuPkg::frameTicks_t  ticks;
    apuPkg::volume_t      volume;
    apuPkg::timerPeriod_t curPeriod;
    logic                 restart;
    logic                 sweepMute;
    logic                 timerTick;  // wave gen back to sweep

    pulseRegDecode i_regDecode (
        .cpu_clk   (cpu_clk),
        .rstn      (rstn),
        .writeEn   (writeEn),
        .writeAddr (writeAddr),
        .writeData (writeData),
        .cfg       (cfg),
        .restart   (restart)
    );

    apuFrameSequencer i_frameSequencer (
        .cpu_clk    (cpu_clk),
        .rstn       (rstn),
        .frameTick  (frameTick),
        .stepSel    (stepSel),
        .enableIntr (enableIntr),
        .ticks      (ticks),
        .frameIrq   (frameIrq)
    );

    pulseEnvelope i_envelope (
        .cpu_clk     (cpu_clk),
        .rstn        (rstn),
        .cfg         (cfg),
        .restart     (restart),
        .quarterTick (ticks.quarterTick),
        .volume      (volume)
    );

    pulseSweep #(
        .SWEEP_MUTE_MIN (SWEEP_MUTE_MIN)
    ) i_sweep (
        .cpu_clk   (cpu_clk),
        .rstn      (rstn),
        .cfg       (cfg),
        .restart   (restart),
        .halfTick  (ticks.halfTick),
        .timerTick (timerTick),
        .curPeriod (curPeriod),
        .sweepMute (sweepMute)
    );

    pulseWaveGen i_waveGen (
        .cpu_clk   (cpu_clk),
        .rstn      (rstn),
        .cfg       (cfg),
        .restart   (restart),
        .halfTick  (ticks.halfTick),
        .curPeriod (curPeriod),
        .sweepMute (sweepMute),
        .volume    (volume),
        .timerTick (timerTick),
        .outVolume (outVolume)
    );

endmodule

// ==== tb/tbApuPulse.sv ====
module tbApuPulse;

    localparam int MAX_CASES    = 32;
    localparam int WAIT_LIMIT   = 20000;  // cycles for any single wait
    localparam int STROBE_LIMIT = 400;

    logic             cpu_clk;
    logic             rstn;
    logic             writeEn;
    logic [1:0]       writeAddr;
    apuPkg::regByte_t writeData;
    logic             frameTick;
    logic             stepSel;
    logic             enableIntr;
    apuPkg::volume_t  outVolume;
    logic             frameIrq;

    logic [15:0]      patMem [256];  // 8 words per case
    apuPkg::regByte_t ctrl0;
    apuPkg::regByte_t ctrl1;
    apuPkg::regByte_t ctrl2;
    apuPkg::regByte_t ctrl3;
    int               expVal;
    int               stepModel;     // where the sequencer should be
    logic             irqModel;
    int               caseCount;

    apuPulseTop #(
        .SWEEP_MUTE_MIN (8)
    ) i_apuPulseTop (
        .cpu_clk    (cpu_clk),
        .rstn       (rstn),
        .writeEn    (writeEn),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .frameTick  (frameTick),
        .stepSel    (stepSel),
        .enableIntr (enableIntr),
        .outVolume  (outVolume),
        .frameIrq   (frameIrq)
    );

    initial begin
        cpu_clk = 1'b0;
        forever begin
            #50 cpu_clk = ~cpu_clk;
        end
    end

    function automatic int patWord(input int index);
        logic [7:0] addr;
        addr = 8'(index);
        return int'(patMem[addr]);
    endfunction

    function automatic int periodField();
        return int'({ctrl3[2:0], ctrl2});
    endfunction

    task automatic reportFail(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkValue(input int got, input int exp, input string what);
        assert (got == exp) else begin
            reportFail($sformatf("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic applyReset();
        @(negedge cpu_clk);
        rstn      = 1'b0;
        writeEn   = 1'b0;
        frameTick = 1'b0;
        repeat (16) begin
            @(negedge cpu_clk);
            checkValue(int'(outVolume), 0, "outVolume during reset");
            checkValue(int'(frameIrq), 0, "frameIrq during reset");
        end
        rstn = 1'b1;
        @(negedge cpu_clk);
        checkValue(int'(outVolume), 0, "outVolume after reset");
        checkValue(int'(frameIrq), 0, "frameIrq after reset");
        stepModel = 0;
        irqModel  = 1'b0;
    endtask

    task automatic writeReg(input logic [1:0] addr, input apuPkg::regByte_t data);
        @(negedge cpu_clk);
        writeEn   = 1'b1;
        writeAddr = addr;
        writeData = data;
        @(negedge cpu_clk);
        writeEn = 1'b0;
    endtask

    // sends one frame strobe after a random gap and predicts its ticks
    task automatic sendStrobe(output bit gotQuarter, output bit gotHalf);
        int gap;
        gap = 40 + int'($urandom % 24);
        repeat (gap) @(negedge cpu_clk);
        frameTick = 1'b1;
        @(negedge cpu_clk);
        frameTick = 1'b0;
        if (!stepSel) begin
            gotQuarter = 1'b1;
            gotHalf    = (stepModel == 1) || (stepModel == 3);
            if ((stepModel == 3) && enableIntr) begin
                irqModel = 1'b1;
            end
            stepModel = (stepModel == 3) ? 0 : stepModel + 1;
        end else begin
            gotQuarter = (stepModel <= 3);
            gotHalf    = (stepModel == 1) || (stepModel == 4);
            stepModel  = (stepModel == 4) ? 0 : stepModel + 1;
        end
        repeat (4) @(negedge cpu_clk);  // ticks settle into the channel
    endtask

    task automatic waitOutput(input bit wantHigh);
        int n;
        n = 0;
        while ((outVolume != '0) != wantHigh) begin
            @(negedge cpu_clk);
            n++;
            if (n > WAIT_LIMIT) begin
                reportFail("timed out waiting for outVolume to change");
            end
        end
    endtask

    // skips one high run so a period change cannot land inside the measured one
    task automatic measureRun(output int runLen, input apuPkg::volume_t level);
        waitOutput(1'b0);
        waitOutput(1'b1);
        waitOutput(1'b0);
        waitOutput(1'b1);
        runLen = 0;
        while (outVolume != '0) begin
            checkValue(int'(outVolume), int'(level), "outVolume level");
            runLen++;
            @(negedge cpu_clk);
            if (runLen > WAIT_LIMIT) begin
                reportFail("timed out measuring a high run of outVolume");
            end
        end
    endtask

    // highest outVolume seen over the window
    task automatic scanPeak(input int window, output int peak);
        peak = 0;
        repeat (window) begin
            @(negedge cpu_clk);
            if (int'(outVolume) > peak) begin
                peak = int'(outVolume);
            end
        end
    endtask

    task automatic dutyHighRun();
        int runLen;
        int highSteps;
        case (ctrl0[7:6])
            2'd0:    highSteps = 1;
            2'd1:    highSteps = 2;
            2'd2:    highSteps = 4;
            default: highSteps = 6;
        endcase
        checkValue(expVal, highSteps * (periodField() + 1), "pattern run length");
        measureRun(runLen, ctrl0[3:0]);
        checkValue(runLen, expVal, "duty high run");
    endtask

    task automatic lengthCountdown();
        int halves;
        int strobes;
        int peak;
        bit q;
        bit h;
        checkValue(expVal, (int'(ctrl3[7:3]) + 1) * 2, "pattern length load");
        halves  = 0;
        strobes = 0;
        peak    = 1;
        while (peak != 0) begin
            sendStrobe(q, h);
            if (h) begin
                halves++;
            end
            scanPeak(8 * (periodField() + 1) + 4, peak);
            strobes++;
            if (strobes > STROBE_LIMIT) begin
                reportFail("length counter never silenced the channel");
            end
        end
        checkValue(halves, expVal, "half ticks until silence");
    endtask

    task automatic envelopeDecay();
        int quarters;
        int strobes;
        int divide;
        int drops;
        int level;
        int peak;
        bit q;
        bit h;
        divide   = int'(ctrl0[3:0]) + 1;
        quarters = 0;
        strobes  = 0;
        scanPeak(8 * (periodField() + 1) + 4, peak);
        checkValue(peak, 15, "envelope start level");
        while (quarters < expVal) begin
            sendStrobe(q, h);
            strobes++;
            if (strobes > STROBE_LIMIT) begin
                reportFail("envelope test ran out of frame strobes");
            end
            if (q) begin
                quarters++;
                drops = quarters / divide;
                if (ctrl0[5]) begin
                    level = (15 - drops) & 15;  // loop wraps 0 to 15
                end else begin
                    level = (drops >= 15) ? 0 : 15 - drops;
                end
                scanPeak(8 * (periodField() + 1) + 4, peak);
                checkValue(peak, level, "envelope level");
            end
        end
    endtask

    task automatic sweepSteps();
        int period;
        int halves;
        int updates;
        int strobes;
        int runLen;
        bit q;
        bit h;
        period  = periodField();
        halves  = 0;
        updates = 0;
        strobes = 0;
        measureRun(runLen, ctrl0[3:0]);
        checkValue(runLen, 4 * (period + 1), "sweep start run");
        while (updates < expVal) begin
            sendStrobe(q, h);
            strobes++;
            if (strobes > STROBE_LIMIT) begin
                reportFail("sweep test ran out of frame strobes");
            end
            if (h) begin
                halves++;
            end
            if (halves == int'(ctrl1[6:4]) + 1) begin
                halves = 0;
                if (ctrl1[3]) begin
                    period = period - (period >> ctrl1[2:0]);
                end else begin
                    period = period + (period >> ctrl1[2:0]);
                end
                updates++;
                measureRun(runLen, ctrl0[3:0]);
                checkValue(runLen, 4 * (period + 1), "sweep high run");
            end
        end
    endtask

    task automatic irqSequence();
        int n;
        bit q;
        bit h;
        for (n = 1; n <= 10; n++) begin
            sendStrobe(q, h);
            checkValue(int'(frameIrq), int'(irqModel), "frameIrq after strobe");
        end
        checkValue(int'(irqModel), expVal, "pattern irq expectation");
        enableIntr = 1'b0;
        repeat (2) @(negedge cpu_clk);
        checkValue(int'(frameIrq), 0, "frameIrq after enableIntr drop");
    endtask

    initial begin
        int base;
        int peak;
        rstn       = 1'b0;
        writeEn    = 1'b0;
        writeAddr  = '0;
        writeData  = '0;
        frameTick  = 1'b0;
        stepSel    = 1'b0;
        enableIntr = 1'b0;
        void'($urandom(32'h8c98));
        foreach (patMem[i]) begin
            patMem[i] = '0;
        end
        $readmemh("tb/pulsePatterns.txt", patMem);
        caseCount = 0;
        while ((caseCount < MAX_CASES) && (patWord(caseCount * 8) != 0)) begin
            base   = caseCount * 8;
            ctrl0  = 8'(patWord(base + 1));
            ctrl1  = 8'(patWord(base + 2));
            ctrl2  = 8'(patWord(base + 3));
            ctrl3  = 8'(patWord(base + 4));
            expVal = patWord(base + 7);
            applyReset();  // every case starts from step 0
            stepSel    = patWord(base + 5) != 0;
            enableIntr = patWord(base + 6) != 0;
            writeReg(2'd0, ctrl0);
            writeReg(2'd1, ctrl1);
            writeReg(2'd2, ctrl2);
            writeReg(2'd3, ctrl3);  // restart
            case (patWord(base))
                1: dutyHighRun();
                2: lengthCountdown();
                3: envelopeDecay();
                4: sweepSteps();
                5: begin
                    scanPeak(expVal, peak);
                    checkValue(peak, 0, "muted outVolume peak");
                end
                6: irqSequence();
                default: reportFail("unknown test kind in the pattern file");
            endcase
            caseCount++;
        end
        if (caseCount > 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            reportFail("no test cases were found in the pattern file");
        end
    end

endmodule

// ==== tb/pulsePatterns.txt ====
// kind reg0 reg1 reg2 reg3 stepSel enableIntr expected, all hex
// kind 1 duty run, 2 length halves, 3 envelope quarters, 4 sweep updates, 5 mute cycles, 6 irq
1 39 00 0a 00 0 0 000b
1 75 00 08 00 0 0 0012
1 bf 00 1f 00 0 0 0080
1 f3 00 05 01 0 0 0624
2 98 00 08 00 0 0 0002
2 98 00 08 18 0 0 0008
2 98 00 08 30 0 0 000e
2 98 00 08 10 1 0 0006
3 c1 00 08 f8 0 0 0028
3 e0 00 08 00 0 0 0024
3 e2 00 08 00 1 0 001e
4 ba 92 40 00 0 0 0003
4 ba 89 c8 00 0 0 0003
5 ba 00 05 00 0 0 0190
5 ba 81 00 07 0 0 0190
6 00 00 00 00 0 1 0001
6 00 00 00 00 1 1 0000
0 00 00 00 00 0 0 0000

// ==== vlog.f ====
source/apuPkg.sv
source/pulseRegDecode.sv
source/apuFrameSequencer.sv
source/pulseEnvelope.sv
source/pulseSweep.sv
source/pulseWaveGen.sv
source/apuPulseTop.sv
tb/tbApuPulse.sv

// ==== Makefile ====
TOP := tbApuPulse

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
